//--- design/motorDrive_config.svh
`ifndef MOTOR_DRIVE_CONFIG_SVH
`define MOTOR_DRIVE_CONFIG_SVH

// Counter widths.
`define MD_CNT_WIDTH    25
`define MD_SPLIT_WIDTH  2
`define MD_REV_WIDTH    16

// Sub-step period in clock cycles.
`define MD_PERIOD_INIT  40
`define MD_PERIOD_MIN   8
`define MD_PERIOD_MAX   200
`define MD_PERIOD_STEP  4   // Change per ramp pulse.

// Cycles with both gates off between legs.
`define MD_DEAD_CYCLES  3

`endif

//--- design/motorDrivePkg.sv
`include "motorDrive_config.svh"

package motorDrivePkg;

    // Step index of one phase. Positions 0 to 11 are active.
    typedef logic [3:0] stepIndex_t;

    typedef logic [`MD_CNT_WIDTH-1:0]   period_t;
    typedef logic [`MD_SPLIT_WIDTH-1:0] split_t;

    localparam stepIndex_t STEPS_PER_REV  = 4'd12;
    localparam stepIndex_t STEP_IDLE      = 4'd15;   // All gates off.

    // Phase B lags A by 120 degrees, phase C by 240 degrees.
    localparam stepIndex_t PHASE_B_OFFSET = 4'd8;
    localparam stepIndex_t PHASE_C_OFFSET = 4'd4;

    // Last index of the high-side half of the table.
    localparam stepIndex_t HIGH_SIDE_LAST = 4'd5;

endpackage

//--- design/speedRamp.sv
`timescale 1ns/1ns
`include "motorDrive_config.svh"

module speedRamp (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   freqInc,
    input  logic                   freqDec,
    output motorDrivePkg::period_t periodSet
);

    import motorDrivePkg::*;

    localparam period_t PERIOD_INIT = `MD_PERIOD_INIT;
    localparam period_t PERIOD_MIN  = `MD_PERIOD_MIN;
    localparam period_t PERIOD_MAX  = `MD_PERIOD_MAX;
    localparam period_t PERIOD_STEP = `MD_PERIOD_STEP;

    period_t periodNext;

    // A higher frequency means a shorter sub-step period.
    always_comb begin
        periodNext = periodSet;
        if (freqInc && !freqDec) begin
            if (periodSet < PERIOD_MIN + PERIOD_STEP) begin
                periodNext = PERIOD_MIN;
            end else begin
                periodNext = periodSet - PERIOD_STEP;
            end
        end else if (freqDec && !freqInc) begin
            if (periodSet > PERIOD_MAX - PERIOD_STEP) begin
                periodNext = PERIOD_MAX;
            end else begin
                periodNext = periodSet + PERIOD_STEP;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            periodSet <= PERIOD_INIT;
        end else begin
            periodSet <= periodNext;   // Both pulses at once leave it unchanged.
        end
    end

    // The step generator relies on a period inside the limits.
    periodInRange: assert property (
        @(posedge clk) disable iff (reset)
        (periodSet >= PERIOD_MIN) && (periodSet <= PERIOD_MAX)
    ) else $error("periodSet %0d outside the configured limits", periodSet);

endmodule

//--- design/stepGenerator.sv
`timescale 1ns/1ns
`include "motorDrive_config.svh"

module stepGenerator (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  motorDrivePkg::period_t      periodSet,
    input  motorDrivePkg::split_t       splitMax,
    output motorDrivePkg::stepIndex_t   stepA,
    output motorDrivePkg::stepIndex_t   stepB,
    output motorDrivePkg::stepIndex_t   stepC,
    output logic [`MD_REV_WIDTH-1:0]    revolutions
);

    import motorDrivePkg::*;

    // Derived phases show this while phase A is idle.
    localparam stepIndex_t DERIVED_IDLE = 4'd14;

    logic    startDly;
    logic    startRise;
    period_t cnt;
    split_t  splitCnt;
    logic    cntLast;
    logic    subStepEnd;
    logic    stepEnd;
    logic    stepWrap;

    // Adds a phase offset to an active index, modulo twelve.
    function automatic stepIndex_t shiftStep(input stepIndex_t step,
                                             input stepIndex_t offset);
        logic [4:0] sum;
        sum = {1'b0, step} + {1'b0, offset};
        if (sum >= {1'b0, STEPS_PER_REV}) begin
            sum = sum - {1'b0, STEPS_PER_REV};
        end
        return sum[3:0];
    endfunction

    assign startRise  = start && !startDly;
    assign cntLast    = (cnt <= period_t'(1));
    assign subStepEnd = start && !startRise && cntLast;
    assign stepEnd    = subStepEnd && (splitCnt == '0);
    assign stepWrap   = stepEnd && (stepA == STEPS_PER_REV - 4'd1);

    always_ff @(posedge clk) begin
        if (reset) begin
            startDly <= 1'b0;
        end else begin
            startDly <= start;
        end
    end

    // Sub-step counter. A new period is only picked up on reload.
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (startRise || subStepEnd) begin
            cnt <= periodSet;
        end else if (start) begin
            cnt <= cnt - period_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            splitCnt <= '0;
        end else if (startRise) begin
            splitCnt <= splitMax;
        end else if (subStepEnd) begin
            if (splitCnt == '0) begin
                splitCnt <= splitMax;   // Last split of this step.
            end else begin
                splitCnt <= splitCnt - split_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stepA <= STEP_IDLE;
        end else if (startRise) begin
            stepA <= '0;
        end else if (stepWrap) begin
            stepA <= '0;
        end else if (stepEnd) begin
            stepA <= stepA + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            revolutions <= '0;
        end else if (!start) begin
            revolutions <= '0;
        end else if (stepWrap) begin
            revolutions <= revolutions + 1'b1;
        end
    end

    always_comb begin
        if (stepA < STEPS_PER_REV) begin
            stepB = shiftStep(stepA, PHASE_B_OFFSET);
            stepC = shiftStep(stepA, PHASE_C_OFFSET);
        end else begin
            stepB = DERIVED_IDLE;
            stepC = DERIVED_IDLE;
        end
    end

    // Phase A only ever holds an active position or the idle code.
    stepAValid: assert property (
        @(posedge clk) disable iff (reset)
        (stepA < STEPS_PER_REV) || (stepA == STEP_IDLE)
    ) else $error("stepA reached unused value %0d", stepA);

endmodule

//--- design/phaseDriver.sv
`timescale 1ns/1ns
`include "motorDrive_config.svh"

module phaseDriver (
    input  logic                      clk,
    input  logic                      reset,
    input  motorDrivePkg::stepIndex_t step,
    output logic                      gateHigh,
    output logic                      gateLow
);

    import motorDrivePkg::*;

    localparam int DEAD_WIDTH = $clog2(`MD_DEAD_CYCLES + 1);
    localparam logic [DEAD_WIDTH-1:0] DEAD_DONE = DEAD_WIDTH'(`MD_DEAD_CYCLES - 1);

    typedef enum logic [1:0] {
        LegOff,
        LegHigh,
        LegLow
    } leg_t;

    leg_t                  wantLeg;
    leg_t                  activeLeg;
    logic [DEAD_WIDTH-1:0] deadCnt;    // Cycles spent with both gates off.
    logic                  deadServed;

    always_comb begin
        if (step <= HIGH_SIDE_LAST) begin
            wantLeg = LegHigh;
        end else if (step < STEPS_PER_REV) begin
            wantLeg = LegLow;
        end else begin
            wantLeg = LegOff;   // Idle and derived-idle codes.
        end
    end

    always_comb begin
        if (gateHigh) begin
            activeLeg = LegHigh;
        end else if (gateLow) begin
            activeLeg = LegLow;
        end else begin
            activeLeg = LegOff;
        end
    end

    // The current cycle completes the dead time.
    assign deadServed = (deadCnt == DEAD_DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            gateHigh <= 1'b0;
            gateLow  <= 1'b0;
            deadCnt  <= DEAD_DONE;
        end else if (activeLeg != LegOff) begin
            if (wantLeg != activeLeg) begin
                // Leave the leg at once; the new one waits out the dead time.
                gateHigh <= 1'b0;
                gateLow  <= 1'b0;
                deadCnt  <= '0;
            end
        end else begin
            if (deadServed) begin
                gateHigh <= (wantLeg == LegHigh);
                gateLow  <= (wantLeg == LegLow);
            end else begin
                deadCnt <= deadCnt + 1'b1;
            end
        end
    end

    // The two switches of one leg must never conduct together.
    noShootThrough: assert property (
        @(posedge clk) disable iff (reset)
        !(gateHigh && gateLow)
    ) else $error("gateHigh and gateLow both on at step %0d", step);

endmodule

//--- design/motorDriveTop.sv
`timescale 1ns/1ns
`include "motorDrive_config.svh"

module motorDriveTop (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      freqInc,
    input  logic                      freqDec,
    input  motorDrivePkg::split_t     splitMax,
    output logic                      gateHighA,
    output logic                      gateLowA,
    output logic                      gateHighB,
    output logic                      gateLowB,
    output logic                      gateHighC,
    output logic                      gateLowC,
    output motorDrivePkg::stepIndex_t stepA,
    output motorDrivePkg::period_t    periodSet,
    output logic [`MD_REV_WIDTH-1:0]  revolutions
);

    import motorDrivePkg::*;

    stepIndex_t stepB;
    stepIndex_t stepC;

    speedRamp i_speedRamp (
        .clk       (clk),
        .reset     (reset),
        .freqInc   (freqInc),
        .freqDec   (freqDec),
        .periodSet (periodSet)
    );

    stepGenerator i_stepGenerator (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .periodSet   (periodSet),
        .splitMax    (splitMax),
        .stepA       (stepA),
        .stepB       (stepB),
        .stepC       (stepC),
        .revolutions (revolutions)
    );

    // One gate driver per motor phase.
    phaseDriver i_phaseDriverA (
        .clk      (clk),
        .reset    (reset),
        .step     (stepA),
        .gateHigh (gateHighA),
        .gateLow  (gateLowA)
    );

    phaseDriver i_phaseDriverB (
        .clk      (clk),
        .reset    (reset),
        .step     (stepB),
        .gateHigh (gateHighB),
        .gateLow  (gateLowB)
    );

    phaseDriver i_phaseDriverC (
        .clk      (clk),
        .reset    (reset),
        .step     (stepC),
        .gateHigh (gateHighC),
        .gateLow  (gateLowC)
    );

endmodule

//--- verif/motorDriveChecker.sv
`timescale 1ns/1ns
`include "motorDrive_config.svh"

module motorDriveChecker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      freqInc,
    input  logic                      freqDec,
    input  motorDrivePkg::split_t     splitMax,
    input  logic                      gateHighA,
    input  logic                      gateLowA,
    input  logic                      gateHighB,
    input  logic                      gateLowB,
    input  logic                      gateHighC,
    input  logic                      gateLowC,
    input  motorDrivePkg::stepIndex_t stepA,
    input  motorDrivePkg::period_t    periodSet,
    input  logic [`MD_REV_WIDTH-1:0]  revolutions,
    output int                        errorCount,
    output int                        checkCount,
    output int                        intervalChecks
);

    import motorDrivePkg::*;

    localparam int DEAD = `MD_DEAD_CYCLES;

    logic [2:0] gateHigh;
    logic [2:0] gateLow;

    int   expPeriod;
    int   expStep;
    int   expRev;
    int   subLeft;        // Cycles left in the running sub-step.
    int   splitLeft;      // Sub-steps still to come in this step.
    logic startSeen;
    int   expLeg [3];     // 0 off, 1 high side, 2 low side.
    int   offCycles [3];
    int   lastStepA;
    int   dutSince;
    logic intervalSteady;
    logic periodMoved;
    int   nextPeriod;
    int   want;
    int   dutLeg;

    assign gateHigh = {gateHighC, gateHighB, gateHighA};
    assign gateLow  = {gateLowC, gateLowB, gateLowA};

    // Indices 0 to 5 call for the high side, 6 to 11 for the low side.
    function automatic int legOf(input int index);
        if (index >= 0 && index <= 5) begin
            return 1;
        end else if (index >= 6 && index <= 11) begin
            return 2;
        end
        return 0;
    endfunction

    function automatic int phaseStep(input int stepIdx, input int phase);
        int offset;
        offset = (phase == 1) ? 8 : ((phase == 2) ? 4 : 0);
        if (stepIdx > 11) begin
            return 14;
        end
        return (stepIdx + offset) % 12;
    endfunction

    task automatic compare(input string what, input int got, input int expected);
        checkCount++;
        if (got != expected) begin
            errorCount++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            expPeriod      = `MD_PERIOD_INIT;
            expStep        = 15;
            expRev         = 0;
            subLeft        = 0;
            splitLeft      = 0;
            startSeen      = 1'b0;
            lastStepA      = 15;
            dutSince       = 0;
            intervalSteady = 1'b0;
            periodMoved    = 1'b0;
            errorCount     = 0;
            checkCount     = 0;
            intervalChecks = 0;
            for (int p = 0; p < 3; p++) begin
                expLeg[p]    = 0;
                offCycles[p] = DEAD;   // Nothing is owed coming out of reset.
            end
        end else begin
            compare("periodSet", int'(periodSet), expPeriod);
            compare("stepA", int'(stepA), expStep);
            compare("revolutions", int'(revolutions), expRev);
            for (int p = 0; p < 3; p++) begin
                dutLeg = gateHigh[p] ? (gateLow[p] ? 3 : 1) : (gateLow[p] ? 2 : 0);
                compare(p == 0 ? "phase A leg" : (p == 1 ? "phase B leg" : "phase C leg"),
                        dutLeg, expLeg[p]);
            end

            // Step length measured on the DUT, over steps that saw a single period.
            if (int'(stepA) != lastStepA) begin
                if (intervalSteady && lastStepA < 12) begin
                    intervalChecks++;
                    compare("step interval", dutSince, expPeriod * (int'(splitMax) + 1));
                end
                dutSince       = 1;
                intervalSteady = !periodMoved;
                lastStepA      = int'(stepA);
            end else begin
                dutSince++;
            end

            // Gates follow the index one cycle late, with dead time between legs.
            for (int p = 0; p < 3; p++) begin
                want = legOf(phaseStep(expStep, p));
                if (expLeg[p] != 0) begin
                    if (want != expLeg[p]) begin
                        expLeg[p]    = 0;
                        offCycles[p] = 1;
                    end
                end else if (offCycles[p] >= DEAD) begin
                    expLeg[p] = want;
                end else begin
                    offCycles[p]++;
                end
            end

            if (start && !startSeen) begin
                subLeft   = expPeriod;
                splitLeft = int'(splitMax);
                expStep   = 0;
            end else if (start) begin
                subLeft--;
                if (subLeft == 0) begin
                    subLeft = expPeriod;   // A new period counts from a reload on.
                    if (splitLeft > 0) begin
                        splitLeft--;
                    end else begin
                        splitLeft = int'(splitMax);
                        expRev    = (expStep == 11) ? expRev + 1 : expRev;
                        expStep   = (expStep + 1) % 12;
                    end
                end
            end
            if (!start) begin
                expRev         = 0;
                intervalSteady = 1'b0;
            end
            startSeen = start;

            nextPeriod = expPeriod;
            if (freqInc && !freqDec) begin
                nextPeriod = expPeriod - `MD_PERIOD_STEP;
                if (nextPeriod < `MD_PERIOD_MIN) begin
                    nextPeriod = `MD_PERIOD_MIN;
                end
            end else if (freqDec && !freqInc) begin
                nextPeriod = expPeriod + `MD_PERIOD_STEP;
                if (nextPeriod > `MD_PERIOD_MAX) begin
                    nextPeriod = `MD_PERIOD_MAX;
                end
            end
            periodMoved = (nextPeriod != expPeriod);
            if (periodMoved) begin
                intervalSteady = 1'b0;
            end
            expPeriod = nextPeriod;
        end
    end

endmodule

//--- verif/motorDriveTb.sv
`timescale 1ns/1ns
`include "motorDrive_config.svh"

module motorDriveTb;

    import motorDrivePkg::*;

    // Steps waited for in tests 2 to 5, each at worst period and split count,
    // plus the ramp pulses of test 4 with their gaps.
    localparam int RUN_STEPS   = 13 + 12 + 5 + 40;
    localparam int RUN_PULSES  = 12 + 4 + 50 + 30;
    localparam int STEP_WORST  = `MD_PERIOD_MAX * (2 ** `MD_SPLIT_WIDTH);
    localparam int CYCLE_LIMIT = RUN_STEPS * STEP_WORST + RUN_PULSES * 6 + 500;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     start;
    logic                     freqInc;
    logic                     freqDec;
    split_t                   splitMax;
    logic                     gateHighA;
    logic                     gateLowA;
    logic                     gateHighB;
    logic                     gateLowB;
    logic                     gateHighC;
    logic                     gateLowC;
    stepIndex_t               stepA;
    period_t                  periodSet;
    logic [`MD_REV_WIDTH-1:0] revolutions;
    int                       errorCount;
    int                       checkCount;
    int                       intervalChecks;
    int                       cycleCount = 0;
    int                       testCount = 0;
    int                       errorsBefore = 0;

    motorDriveTop i_dut (.*);

    motorDriveChecker i_checker (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // Waits for the given number of changes of stepA.
    task automatic waitSteps(input int count);
        stepIndex_t last;
        int         seen;
        seen = 0;
        last = stepA;
        while (seen < count) begin
            @(posedge clk);
            if (stepA != last) begin
                seen++;
                last = stepA;
            end
        end
    endtask

    task automatic rampPulse(input logic inc, input logic dec);
        @(posedge clk);
        freqInc <= inc;
        freqDec <= dec;
        @(posedge clk);
        freqInc <= 1'b0;
        freqDec <= 1'b0;
        repeat ($urandom % 4) @(posedge clk);
    endtask

    task automatic endTest(input string name);
        int errors;
        @(negedge clk);
        errors = errorCount - errorsBefore;
        testCount++;
        $display("Test %0d, %s: %0d errors", testCount, name, errors);
        errorsBefore = errorCount;
    endtask

    initial begin
        int kind;
        int turns;
        void'($urandom(32'h55a9_4bc5));
        reset    <= 1'b1;
        start    <= 1'b0;
        freqInc  <= 1'b0;
        freqDec  <= 1'b0;
        splitMax <= '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        repeat (10) @(posedge clk);
        endTest("reset state");

        @(posedge clk);
        splitMax <= split_t'($urandom % 4);
        @(posedge clk);
        start <= 1'b1;
        waitSteps(13);   // The jump from idle to 0, then one full turn.
        endTest("step timing");

        waitSteps(12);
        endTest("gate mapping");

        repeat (12) rampPulse(1'b1, 1'b0);
        repeat (4) rampPulse(1'b1, 1'b1);
        waitSteps(2);
        repeat (50) rampPulse(1'b0, 1'b1);
        repeat (30) begin
            kind = $urandom % 3;
            rampPulse(kind != 1, kind != 0);
        end
        waitSteps(3);
        endTest("speed ramp");

        turns = 2 + ($urandom % 2);
        @(posedge clk);
        start <= 1'b0;
        repeat (4) @(posedge clk);
        splitMax <= split_t'($urandom % 4);
        start    <= 1'b1;
        while (int'(revolutions) != turns) begin
            @(posedge clk);
        end
        waitSteps(1);
        @(posedge clk);
        start <= 1'b0;
        repeat (20) @(posedge clk);
        start <= 1'b1;
        waitSteps(2);
        endTest("revolutions and stop");

        $display("Summary: %0d tests, %0d checks, %0d step intervals, %0d errors",
                 testCount, checkCount, intervalChecks, errorCount);
        if (intervalChecks == 0) begin
            $display("No step interval was measured, so step timing went unchecked.");
        end
        if (errorCount == 0 && intervalChecks > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+design
design/motorDrivePkg.sv
design/speedRamp.sv
design/stepGenerator.sv
design/phaseDriver.sv
design/motorDriveTop.sv
verif/motorDriveChecker.sv
verif/motorDriveTb.sv

//--- Makefile
# Verilator build for the motor drive commutation core.

TOP       ?= motorDriveTb
SEED      ?= 1
LOG       ?= sim.log
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator

SOURCES := $(shell grep -v '^+' $(FILELIST)) design/motorDrive_config.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	$(SIM_BIN) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q -F '*** PASSED ***' $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
